/* Bender.yml */
package:
  name: fetch_front_end

export_include_dirs:
  - hw

sources:
  - hw/fetch_pkg.sv
  - hw/inst_sram_pkg.sv
  - hw/pc_gen.sv
  - hw/if_stage.sv
  - hw/inst_sram.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - verification/fetch_props.sv
      - verification/fetch_tb.sv

/* all.f */
+incdir+hw
hw/fetch_pkg.sv
hw/inst_sram_pkg.sv
hw/pc_gen.sv
hw/if_stage.sv
hw/inst_sram.sv
hw/fetch_top.sv
verification/fetch_props.sv
verification/fetch_tb.sv

/* hw/fetch_defs.svh */
// fetch front end widths, reset pc and memory size; include wherever these values are needed
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// datapath widths
`define FETCH_PC_WD          32
`define FETCH_INST_WD        32
`define FETCH_SRAM_DATA_WD   64   // one memory beat holds two instructions
`define FETCH_SRAM_ADDR_WD   32

// first fetch address out of reset
`define FETCH_PC_RESETVAL    32'h8000_0000

// 64-bit words in the instruction memory indexed by addr[7:3]
`define FETCH_MEM_WORDS      32

`endif

/* hw/fetch_pkg.sv */
// pipeline bus types between the fetch stage and decode; import where these buses are used
package fetch_pkg;

  `include "fetch_defs.svh"

  // branch bus from decode
  typedef struct packed {
    logic                      stall;   // load-to-branch hazard, hold fetch
    logic                      taken;   // redirect request
    logic [`FETCH_PC_WD-1:0]   target;  // redirect pc
  } br_bus_t;

  // fetched item handed to decode
  typedef struct packed {
    logic [`FETCH_INST_WD-1:0] inst;
    logic [`FETCH_PC_WD-1:0]   pc;
  } fs_to_ds_bus_t;

endpackage

/* hw/fetch_top.sv */
// fetch front end top, fetch stage plus instruction memory; the unit under test
`timescale 1ns/1ps

module fetch_top
  import fetch_pkg::*;
  import inst_sram_pkg::*;
#(
  parameter int MEM_LATENCY = 1
) (
  input  logic          i_clk,
  input  logic          i_reset,
  input  br_bus_t       i_br_bus,
  input  logic          i_ds_allowin,
  output logic          o_fs_to_ds_valid,
  output fs_to_ds_bus_t o_fs_to_ds_bus
);

  inst_sram_req_t sram_req;
  inst_sram_rsp_t sram_rsp;

  if_stage u_if_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_allowin     (i_ds_allowin),
    .i_br_bus         (i_br_bus),
    .o_fs_to_ds_valid (o_fs_to_ds_valid),
    .o_fs_to_ds_bus   (o_fs_to_ds_bus),
    .o_sram_req       (sram_req),
    .i_sram_rsp       (sram_rsp)
  );

  inst_sram #(
    .LATENCY (MEM_LATENCY)
  ) u_inst_sram (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (sram_req),
    .o_rsp   (sram_rsp)
  );

endmodule

/* hw/if_stage.sv */
// instruction fetch stage with pre-fetch issue and valid/allowin output; used by fetch_top
`timescale 1ns/1ps

`include "fetch_defs.svh"

module if_stage
  import fetch_pkg::*;
  import inst_sram_pkg::*;
(
  input  logic           i_clk,
  input  logic           i_reset,
  // from decode
  input  logic           i_ds_allowin,
  input  br_bus_t        i_br_bus,
  // to decode
  output logic           o_fs_to_ds_valid,
  output fs_to_ds_bus_t  o_fs_to_ds_bus,
  // instruction memory port
  output inst_sram_req_t o_sram_req,
  input  inst_sram_rsp_t i_sram_rsp
);

  logic                      fetch_en_q;   // pre-fetch starts one cycle after reset
  logic                      fs_valid_q;
  logic [`FETCH_PC_WD-1:0]   fs_pc_q;
  logic                      buf_valid_q;  // instruction already returned
  logic [`FETCH_INST_WD-1:0] buf_inst_q;

  logic                      fs_ready_go;
  logic                      fs_allowin;
  logic                      fs_leave;
  logic                      issue;
  logic [`FETCH_PC_WD-1:0]   next_pc;
  logic [`FETCH_INST_WD-1:0] sel_inst;

  // pre-if request goes out whenever the stage can take a new item
  assign o_sram_req.ren = fetch_en_q & fs_allowin & ~i_br_bus.stall;
  assign issue          = o_sram_req.ren & i_sram_rsp.addr_ok;

  assign fs_ready_go = i_sram_rsp.data_ok | buf_valid_q;
  assign fs_allowin  = ~fs_valid_q | (fs_ready_go & i_ds_allowin);
  assign fs_leave    = fs_valid_q & fs_ready_go & i_ds_allowin;

  pc_gen u_pc_gen (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_load      (issue),
    .i_br        (i_br_bus),
    .o_pc        (next_pc),
    .o_sram_addr (o_sram_req.addr)
  );

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fetch_en_q <= 1'b0;
      fs_valid_q <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
      if (fs_allowin) begin
        fs_valid_q <= issue;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (issue) begin
      fs_pc_q <= next_pc;
    end
  end

  // pc[2] picks the word of the 64-bit beat
  assign sel_inst = fs_pc_q[2] ? i_sram_rsp.rdata[63:32] : i_sram_rsp.rdata[31:0];

  // keep the returned word while decode holds us off
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      buf_valid_q <= 1'b0;
    end else if (fs_leave) begin
      buf_valid_q <= 1'b0;
    end else if (i_sram_rsp.data_ok) begin
      buf_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_sram_rsp.data_ok) begin
      buf_inst_q <= sel_inst;
    end
  end

  assign o_fs_to_ds_valid    = fs_valid_q & fs_ready_go;
  assign o_fs_to_ds_bus.inst = buf_valid_q ? buf_inst_q : sel_inst;
  assign o_fs_to_ds_bus.pc   = fs_pc_q;

endmodule

/* hw/inst_sram.sv */
// instruction memory model with addr_ok/data_ok and fixed read latency; behind the fetch stage
`timescale 1ns/1ps

`include "fetch_defs.svh"

module inst_sram
  import inst_sram_pkg::*;
#(
  parameter int LATENCY = 1     // 1 to 4 cycles from accept to data_ok
) (
  input  logic           i_clk,
  input  logic           i_reset,
  input  inst_sram_req_t i_req,
  output inst_sram_rsp_t o_rsp
);

  localparam int         IDX_WD   = $clog2(`FETCH_MEM_WORDS);
  localparam logic [1:0] LAT_INIT = 2'(LATENCY - 1);

  logic [`FETCH_SRAM_DATA_WD-1:0] mem [`FETCH_MEM_WORDS];

  logic              busy_q;
  logic [1:0]        lat_cnt_q;
  logic [IDX_WD-1:0] idx_q;      // word index of the accepted read
  logic              accept;
  logic              data_ok;

  initial begin
    $readmemh("verification/inst_mem.hex", mem);
  end

  assign accept  = i_req.ren & ~busy_q;
  assign data_ok = busy_q & (lat_cnt_q == 2'd0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy_q    <= 1'b0;
      lat_cnt_q <= 2'd0;
    end else if (accept) begin
      busy_q    <= 1'b1;
      lat_cnt_q <= LAT_INIT;
    end else if (data_ok) begin
      busy_q    <= 1'b0;             // one outstanding read at a time
    end else if (busy_q) begin
      lat_cnt_q <= lat_cnt_q - 2'd1;
    end
  end

  // addresses wrap every 256 bytes
  always_ff @(posedge i_clk) begin
    if (accept) begin
      idx_q <= i_req.addr[IDX_WD+2:3];
    end
  end

  assign o_rsp.addr_ok = ~busy_q;
  assign o_rsp.data_ok = data_ok;
  assign o_rsp.rdata   = mem[idx_q];   // only meaningful with data_ok

endmodule

/* hw/inst_sram_pkg.sv */
// request and response types of the instruction memory port; import on both sides of the port
package inst_sram_pkg;

  `include "fetch_defs.svh"

  // read request with an 8-byte aligned addr
  typedef struct packed {
    logic                           ren;
    logic [`FETCH_SRAM_ADDR_WD-1:0] addr;
  } inst_sram_req_t;

  // handshake flags and read data
  typedef struct packed {
    logic                           addr_ok;  // request taken this cycle
    logic                           data_ok;  // rdata valid this cycle
    logic [`FETCH_SRAM_DATA_WD-1:0] rdata;
  } inst_sram_rsp_t;

endpackage

/* hw/pc_gen.sv */
// fetch program counter with a pending redirect; instantiated inside the fetch stage
`timescale 1ns/1ps

`include "fetch_defs.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  logic                           i_clk,
  input  logic                           i_reset,
  input  logic                           i_load,       // fetch issued this cycle
  input  br_bus_t                        i_br,
  output logic [`FETCH_PC_WD-1:0]        o_pc,
  output logic [`FETCH_SRAM_ADDR_WD-1:0] o_sram_addr
);

  localparam logic [`FETCH_PC_WD-1:0] PC_STEP = 4;

  logic [`FETCH_PC_WD-1:0] pc_q;
  logic                    redir_pend_q;
  logic [`FETCH_PC_WD-1:0] redir_target_q;
  logic                    redir;
  logic [`FETCH_PC_WD-1:0] redir_target;
  logic [`FETCH_PC_WD-1:0] pc_next;

  // a taken pulse in the load cycle counts as pending
  assign redir        = redir_pend_q | i_br.taken;
  assign redir_target = i_br.taken ? i_br.target : redir_target_q;
  assign pc_next      = redir ? redir_target : pc_q + PC_STEP;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q         <= `FETCH_PC_RESETVAL;
      redir_pend_q <= 1'b0;
    end else if (i_load) begin
      pc_q         <= pc_next;
      redir_pend_q <= 1'b0;          // consumed by this issue
    end else if (i_br.taken) begin
      redir_pend_q <= 1'b1;          // hold until next issue
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_br.taken) begin
      redir_target_q <= i_br.target;
    end
  end

  assign o_pc        = pc_q;
  assign o_sram_addr = {pc_q[`FETCH_SRAM_ADDR_WD-1:3], 3'b000};  // beat aligned

endmodule

/* verification/fetch_props.sv */
// handshake assertions for the fetch stage; bound into every if_stage instance below
`timescale 1ns/1ps

module fetch_props
  import fetch_pkg::*;
  import inst_sram_pkg::*;
(
  input logic           i_clk,
  input logic           i_reset,
  input logic           i_ds_allowin,
  input logic           i_fs_valid,
  input fs_to_ds_bus_t  i_fs_bus,
  input inst_sram_req_t i_sram_req,
  input inst_sram_rsp_t i_sram_rsp
);

  int   fail_cnt = 0;     // read by the testbench at the end
  logic req_open_q;       // accepted read still waiting for data_ok

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      req_open_q <= 1'b0;
    end else if (i_sram_req.ren && i_sram_rsp.addr_ok) begin
      req_open_q <= 1'b1;
    end else if (i_sram_rsp.data_ok) begin
      req_open_q <= 1'b0;
    end
  end

  // held item keeps valid and its contents
  hold_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_fs_valid && !i_ds_allowin |=> i_fs_valid && $stable(i_fs_bus))
    else begin
      fail_cnt++;
      $error("fetch output changed while decode held it off");
    end

  data_ok_has_req: assert property (@(posedge i_clk) disable iff (i_reset)
    i_sram_rsp.data_ok |-> req_open_q)
    else begin
      fail_cnt++;
      $error("data_ok without an accepted read");
    end

  // once reset has been clocked in, no read goes out
  no_ren_in_reset: assert property (@(posedge i_clk) i_reset |=> !i_sram_req.ren)
    else begin
      fail_cnt++;
      $error("ren high during reset");
    end

endmodule

bind if_stage fetch_props u_fetch_props (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_ds_allowin (i_ds_allowin),
  .i_fs_valid   (o_fs_to_ds_valid),
  .i_fs_bus     (o_fs_to_ds_bus),
  .i_sram_req   (o_sram_req),
  .i_sram_rsp   (i_sram_rsp)
);

/* verification/fetch_tb.sv */
// directed tests for the fetch front end; simulation top, compile with all.f
`timescale 1ns/1ps

`include "fetch_defs.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int CLK_NS        = 4;
  localparam int ITEM_TIMEOUT  = 40;   // cycles allowed per delivery
  localparam int N_SEQ         = 40;
  localparam int N_BR          = 8;
  localparam int N_AFTER_STALL = 6;
  localparam int STALL_CYCLES  = 10;
  localparam int TOTAL_ITEMS   = 1 + 2 * N_SEQ + (N_BR + 1) + (N_AFTER_STALL + 1);
  localparam logic [`FETCH_PC_WD-1:0] BR_TARGET = 32'h8000_00f0;  // runs across the wrap

  logic          clk;
  logic          reset;
  logic          ds_allowin;
  br_bus_t       br_bus;
  logic          fs_valid;
  fs_to_ds_bus_t fs_bus;

  logic [`FETCH_SRAM_DATA_WD-1:0] ref_mem [`FETCH_MEM_WORDS];
  logic [`FETCH_PC_WD-1:0]        exp_pc;
  logic [7:0]                     lfsr_q;
  logic                           took;   // item left the stage this cycle
  int                             value_errs;
  int                             other_errs;
  int                             assert_errs;

  fetch_top #(
    .MEM_LATENCY (2)
  ) DUT (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_br_bus         (br_bus),
    .i_ds_allowin     (ds_allowin),
    .o_fs_to_ds_valid (fs_valid),
    .o_fs_to_ds_bus   (fs_bus)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(TOTAL_ITEMS * ITEM_TIMEOUT * CLK_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  // fibonacci lfsr with taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic next_rand_bit();
    logic fb;
    fb     = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    lfsr_q = {lfsr_q[6:0], fb};
    return fb;
  endfunction

  // pc[7:3] picks the beat and pc[2] the half
  function automatic fs_to_ds_bus_t expected_item(input logic [`FETCH_PC_WD-1:0] pc);
    fs_to_ds_bus_t                  item;
    logic [`FETCH_SRAM_DATA_WD-1:0] beat;
    beat      = ref_mem[pc[7:3]];
    item.pc   = pc;
    item.inst = pc[2] ? beat[63:32] : beat[31:0];
    return item;
  endfunction

  task automatic check_fetch(input string what, input fs_to_ds_bus_t act,
                             input fs_to_ds_bus_t exp);
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0d ns: %s got pc %h inst %h, expected pc %h inst %h",
               $time, what, act.pc, act.inst, exp.pc, exp.inst);
    end
  endtask

  task automatic check_flag(input string what, input logic act, input logic exp);
    if (act !== exp) begin
      value_errs++;
      $display("** Error at %0d ns: %s got %b, expected %b", $time, what, act, exp);
    end
  endtask

  // inputs change 1 ns after the edge and outputs are read at the falling edge
  task automatic drive_cycle(input logic allow, input br_bus_t br);
    @(posedge clk);
    #1;
    ds_allowin = allow;
    br_bus     = br;
    @(negedge clk);
    took = fs_valid & ds_allowin;
  endtask

  task automatic take_seq();
    check_fetch("fetched item", fs_bus, expected_item(exp_pc));
    exp_pc = exp_pc + 4;
  endtask

  task automatic wait_item(input logic rand_allow, input br_bus_t br);
    int idle;
    idle = 0;
    took = 1'b0;
    while (!took && idle < ITEM_TIMEOUT) begin
      drive_cycle(rand_allow ? next_rand_bit() : 1'b1, br);
      idle++;
    end
    if (!took) begin
      other_errs++;
      $display("no item left the fetch stage within %0d cycles", ITEM_TIMEOUT);
    end
  endtask

  task automatic stream_items(input int n, input logic rand_allow);
    repeat (n) begin
      wait_item(rand_allow, '0);
      if (took) take_seq();
    end
  endtask

  task automatic test_reset();
    @(posedge clk);
    @(negedge clk);
    check_flag("valid during reset", fs_valid, 1'b0);
    @(posedge clk);
    #1;
    reset      = 1'b0;
    ds_allowin = 1'b1;
    @(negedge clk);
    check_flag("valid right after reset", fs_valid, 1'b0);
    exp_pc = `FETCH_PC_RESETVAL;
    stream_items(1, 1'b0);
  endtask

  task automatic test_branch();
    br_bus_t br;
    br        = '0;
    br.taken  = 1'b1;
    br.target = BR_TARGET;
    drive_cycle(1'b1, br);               // one-cycle taken pulse
    if (took) take_seq();
    wait_item(1'b0, '0);
    if (took && fs_bus.pc == exp_pc) begin
      take_seq();                        // fetched before the redirect
      wait_item(1'b0, '0);
    end
    exp_pc = BR_TARGET;
    if (took) take_seq();
    stream_items(N_BR - 1, 1'b0);
  endtask

  task automatic test_stall();
    br_bus_t br;
    int      during;
    br       = '0;
    br.stall = 1'b1;
    during   = 0;
    repeat (STALL_CYCLES) begin
      drive_cycle(1'b1, br);
      if (took) begin
        take_seq();
        during++;
      end
    end
    if (during > 1) begin
      other_errs++;
      $display("%0d items left the stage during a stall, at most 1 may", during);
    end
    stream_items(N_AFTER_STALL, 1'b0);   // resumes at the next pc
  endtask

  initial begin
    reset      = 1'b1;
    ds_allowin = 1'b0;
    br_bus     = '0;
    took       = 1'b0;
    lfsr_q     = 8'd61;
    value_errs = 0;
    other_errs = 0;
    $readmemh("verification/inst_mem.hex", ref_mem);
    test_reset();
    stream_items(N_SEQ, 1'b0);   // free consumer
    stream_items(N_SEQ, 1'b1);   // random back-pressure
    test_branch();
    test_stall();
    assert_errs = DUT.u_if_stage.u_fetch_props.fail_cnt;
    $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
             value_errs, other_errs, assert_errs);
    if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verification/inst_mem.hex */
// each line is one 64-bit beat covering 8 bytes of code, line n at byte offset n*8
// left 32 bits hold the word with pc[2]=1 and right 32 bits the word with pc[2]=0
3c01fb042402ff00
3c01f30c2402f708
3c01eb142402ef10
3c01e31c2402e718
3c01db242402df20
3c01d32c2402d728
3c01cb342402cf30
3c01c33c2402c738
3c01bb442402bf40
3c01b34c2402b748
3c01ab542402af50
3c01a35c2402a758
3c019b6424029f60
3c01936c24029768
3c018b7424028f70
3c01837c24028778
3c017b8424027f80
3c01738c24027788
3c016b9424026f90
3c01639c24026798
3c015ba424025fa0
3c0153ac240257a8
3c014bb424024fb0
3c0143bc240247b8
3c013bc424023fc0
3c0133cc240237c8
3c012bd424022fd0
3c0123dc240227d8
3c011be424021fe0
3c0113ec240217e8
3c010bf424020ff0
3c0103fc240207f8
